/* include/eth_fcs_macros.svh */
// Ethernet FCS widths and constants

`ifndef ETH_FCS_MACROS_SVH
`define ETH_FCS_MACROS_SVH

// Stream beat, CRC and FCS sizes
`define ETH_BYTE_W    8
`define ETH_CRC_W     32
`define ETH_FCS_BYTES 4

// CRC register value at the start of every frame
`define ETH_CRC_INIT 32'hFFFF_FFFF

// FCS output after a frame followed by its own correct FCS
`define ETH_FCS_RESIDUE 32'h2144_DF1C

`endif

/* logic/stream_pkg.sv */
// Byte stream types

`default_nettype none

`include "eth_fcs_macros.svh"

package stream_pkg;

	// One data byte per beat
	typedef logic [`ETH_BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

/* logic/eth_pkg.sv */
// Ethernet CRC and FCS appender types

`default_nettype none

`include "eth_fcs_macros.svh"

package eth_pkg;

	// CRC register or FCS value
	typedef logic [`ETH_CRC_W-1:0] crc_t;

	// Selects the FCS byte on the output, byte 0 goes first
	typedef logic [$clog2(`ETH_FCS_BYTES)-1:0] fcs_index_t;

	// Appender phase
	typedef enum logic {
		APPEND_DATA,
		APPEND_FCS
	} append_state_t;

endpackage

`default_nettype wire

/* logic/byte_stream_if.sv */
// Byte stream with valid/ready/last

`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if
	import stream_pkg::*;
();

	logic  valid;
	logic  ready;
	logic  last;
	byte_t data;

	// A beat moves when valid and ready are both high
	modport source (
		output valid, last, data,
		input  ready
	);

	modport sink (
		input  valid, last, data,
		output ready
	);

endinterface

`default_nettype wire

/* logic/eth_crc.sv */
// Byte-wide Ethernet CRC-32 engine

`timescale 1ns/1ps
`default_nettype none

`include "eth_fcs_macros.svh"

module eth_crc
	import stream_pkg::*, eth_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  update,
	input  wire logic  clear,
	input  wire byte_t data,
	output crc_t       fcs,
	output crc_t       fcs_next
);

	// Ethernet generator polynomial, normal form
	localparam crc_t CRC_POLY = 32'h04C1_1DB7;

	crc_t  crc_q;
	crc_t  crc_c;
	byte_t data_refl;

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	function automatic byte_t reflect_byte(byte_t v);
		byte_t r;
		for (int i = 0; i < `ETH_BYTE_W; i++) begin
			r[i] = v[`ETH_BYTE_W-1-i];
		end
		return r;
	endfunction

	function automatic crc_t reflect_crc(crc_t v);
		crc_t r;
		for (int i = 0; i < `ETH_CRC_W; i++) begin
			r[i] = v[`ETH_CRC_W-1-i];
		end
		return r;
	endfunction

	// Unrolls into the parallel XOR network for one byte, MSB of din first
	function automatic crc_t crc_byte(crc_t state, byte_t din);
		crc_t c;
		logic fb;
		c = state;
		for (int i = `ETH_BYTE_W - 1; i >= 0; i--) begin
			fb = c[`ETH_CRC_W-1] ^ din[i];
			c  = {c[`ETH_CRC_W-2:0], 1'b0} ^ ({`ETH_CRC_W{fb}} & CRC_POLY);
		end
		return c;
	endfunction

	// ------------------------------------------------------------------------
	// Datapath
	// ------------------------------------------------------------------------

	// Ethernet sends bit 0 first
	assign data_refl = reflect_byte(data);
	assign crc_c     = crc_byte(crc_q, data_refl);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			crc_q <= `ETH_CRC_INIT;
		end else if (clear) begin
			crc_q <= `ETH_CRC_INIT;
		end else if (update) begin
			crc_q <= crc_c;
		end
	end

	assign fcs      = ~reflect_crc(crc_q);
	assign fcs_next = ~reflect_crc(crc_c);

	a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		update |-> !$isunknown(data));

endmodule

`default_nettype wire

/* logic/eth_fcs_append.sv */
// Transmit FCS appender

`timescale 1ns/1ps
`default_nettype none

`include "eth_fcs_macros.svh"

module eth_fcs_append
	import eth_pkg::*;
(
	input wire logic      clk,
	input wire logic      rst_n,
	byte_stream_if.sink   tx_in,
	byte_stream_if.source tx_out
);

	localparam fcs_index_t LAST_IDX = fcs_index_t'(`ETH_FCS_BYTES - 1);

	append_state_t state_q;
	fcs_index_t    idx_q;
	crc_t          fcs_q;
	crc_t          fcs_next;
	logic          in_fire;
	logic          in_end;
	logic          out_fire;

	assign in_fire  = tx_in.valid && tx_in.ready;
	assign in_end   = in_fire && tx_in.last;
	assign out_fire = tx_out.valid && tx_out.ready;

	// CRC sees every forwarded byte and restarts after the last one
	eth_crc u_crc (
		.clk      (clk),
		.rst_n    (rst_n),
		.update   (in_fire),
		.clear    (in_end),
		.data     (tx_in.data),
		.fcs      (),
		.fcs_next (fcs_next)
	);

	// ------------------------------------------------------------------------
	// Output mux
	// ------------------------------------------------------------------------

	always_comb begin
		if (state_q == APPEND_DATA) begin
			// Pass through, ready only matters while a byte is offered
			tx_out.valid = tx_in.valid;
			tx_out.data  = tx_in.data;
			tx_out.last  = 1'b0;
			tx_in.ready  = !tx_in.valid || tx_out.ready;
		end else begin
			tx_out.valid = 1'b1;
			tx_out.data  = fcs_q[idx_q*`ETH_BYTE_W +: `ETH_BYTE_W];
			tx_out.last  = (idx_q == LAST_IDX);
			tx_in.ready  = 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// Phase and FCS byte counter
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= APPEND_DATA;
			idx_q   <= '0;
		end else begin
			case (state_q)
				APPEND_DATA: begin
					if (in_end) begin
						state_q <= APPEND_FCS;
						idx_q   <= '0;
					end
				end
				APPEND_FCS: begin
					if (out_fire) begin
						// Counter wraps to zero after the last FCS byte
						idx_q <= idx_q + 1'b1;
						if (idx_q == LAST_IDX) begin
							state_q <= APPEND_DATA;
						end
					end
				end
				default: state_q <= APPEND_DATA;
			endcase
		end
	end

	// FCS including the last data byte
	always_ff @(posedge clk) begin
		if (in_end) begin
			fcs_q <= fcs_next;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tx_out.valid && !tx_out.ready |=>
			tx_out.valid && $stable(tx_out.data) && $stable(tx_out.last));

	a_in_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		in_end |=> (!tx_in.ready until_with (out_fire && tx_out.last)));

endmodule

`default_nettype wire

/* logic/eth_fcs_check.sv */
// Receive FCS checker

`timescale 1ns/1ps
`default_nettype none

`include "eth_fcs_macros.svh"

module eth_fcs_check
	import eth_pkg::*;
(
	input wire logic    clk,
	input wire logic    rst_n,
	byte_stream_if.sink rx,
	output logic        frame_ok,
	output logic        frame_bad
);

	crc_t fcs_next;
	logic rx_fire;
	logic rx_end;
	logic fcs_good;

	// Never stalls the receive stream
	assign rx.ready = 1'b1;

	assign rx_fire = rx.valid && rx.ready;
	assign rx_end  = rx_fire && rx.last;

	// Frame bytes and the received FCS all go through the CRC
	eth_crc u_crc (
		.clk      (clk),
		.rst_n    (rst_n),
		.update   (rx_fire),
		.clear    (rx_end),
		.data     (rx.data),
		.fcs      (),
		.fcs_next (fcs_next)
	);

	// A correct frame leaves the fixed residue
	assign fcs_good = (fcs_next == `ETH_FCS_RESIDUE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_ok  <= 1'b0;
			frame_bad <= 1'b0;
		end else begin
			frame_ok  <= rx_end && fcs_good;
			frame_bad <= rx_end && !fcs_good;
		end
	end

	a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
		!(frame_ok && frame_bad));

endmodule

`default_nettype wire

/* logic/eth_fcs_top.sv */
// Ethernet FCS transmit and receive path

`timescale 1ns/1ps
`default_nettype none

module eth_fcs_top
	import stream_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	// Transmit input
	input  wire logic  tx_in_valid,
	output logic       tx_in_ready,
	input  wire logic  tx_in_last,
	input  wire byte_t tx_in_data,
	// Transmit output with FCS
	output logic       tx_out_valid,
	input  wire logic  tx_out_ready,
	output logic       tx_out_last,
	output byte_t      tx_out_data,
	// Receive input
	input  wire logic  rx_valid,
	input  wire logic  rx_last,
	input  wire byte_t rx_data,
	output logic       frame_ok,
	output logic       frame_bad
);

	byte_stream_if tx_in ();
	byte_stream_if tx_out ();
	byte_stream_if rx ();

	assign tx_in.valid = tx_in_valid;
	assign tx_in.last  = tx_in_last;
	assign tx_in.data  = tx_in_data;
	assign tx_in_ready = tx_in.ready;

	assign tx_out_valid = tx_out.valid;
	assign tx_out_last  = tx_out.last;
	assign tx_out_data  = tx_out.data;
	assign tx_out.ready = tx_out_ready;

	// rx ready stays inside, the checker always accepts
	assign rx.valid = rx_valid;
	assign rx.last  = rx_last;
	assign rx.data  = rx_data;

	eth_fcs_append u_append (
		.clk    (clk),
		.rst_n  (rst_n),
		.tx_in  (tx_in.sink),
		.tx_out (tx_out.source)
	);

	eth_fcs_check u_check (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx.sink),
		.frame_ok  (frame_ok),
		.frame_bad (frame_bad)
	);

endmodule

`default_nettype wire

/* testbench/eth_fcs_tb.sv */
// Ethernet FCS path testbench

`timescale 1ns/1ps
`default_nettype none

module eth_fcs_tb
	import stream_pkg::*, eth_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_TESTS    = 32;
	localparam int MAX_BYTES    = 1024;
	localparam TEST_FILE = "testbench/eth_fcs_tests.txt";

	logic  clk;
	logic  rst_n;
	logic  tx_in_valid;
	logic  tx_in_ready;
	logic  tx_in_last;
	byte_t tx_in_data;
	logic  tx_out_valid;
	logic  tx_out_ready;
	logic  tx_out_last;
	byte_t tx_out_data;
	logic  rx_valid;
	logic  rx_last;
	byte_t rx_data;
	logic  frame_ok;
	logic  frame_bad;

	// Test table with frame bytes in frame_mem at off_of
	string mode_of  [0:MAX_TESTS-1];
	string name_of  [0:MAX_TESTS-1];
	int    len_of   [0:MAX_TESTS-1];
	int    off_of   [0:MAX_TESTS-1];
	crc_t  fcs_of   [0:MAX_TESTS-1];
	logic  good_of  [0:MAX_TESTS-1];
	int    errs_of  [0:MAX_TESTS-1];
	int    loop_off [0:MAX_TESTS-1];
	int    loop_len [0:MAX_TESTS-1];
	byte_t frame_mem [0:MAX_BYTES-1];
	byte_t loop_mem  [0:MAX_BYTES-1];

	int     n_tests     = 0;
	int     total_bytes = 0;
	int     n_pass      = 0;
	int     n_fail      = 0;
	int     mon_errs    = 0;
	logic   loaded      = 1'b0;
	logic   fcs_pending = 1'b0;
	integer seed        = 32'h1771;

	eth_fcs_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.tx_in_valid  (tx_in_valid),
		.tx_in_ready  (tx_in_ready),
		.tx_in_last   (tx_in_last),
		.tx_in_data   (tx_in_data),
		.tx_out_valid (tx_out_valid),
		.tx_out_ready (tx_out_ready),
		.tx_out_last  (tx_out_last),
		.tx_out_data  (tx_out_data),
		.rx_valid     (rx_valid),
		.rx_last      (rx_last),
		.rx_data      (rx_data),
		.frame_ok     (frame_ok),
		.frame_bad    (frame_bad)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Random back-pressure on tx_out
	initial begin
		tx_out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			tx_out_ready = ($random(seed) & 3) != 0;
		end
	end

	// ------------------------------------------------------------------------
	// Test file
	// ------------------------------------------------------------------------

	task automatic load_tests();
		int    fd;
		int    r;
		int    c;
		int    len;
		int    next_off;
		string tok;
		string name;
		string res;
		byte_t b;
		next_off = 0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the test file %s", TEST_FILE);
			n_fail++;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok[0] == "#") begin
				c = $fgetc(fd);
				while (c != "\n" && c != -1) begin
					c = $fgetc(fd);
				end
			end else begin
				r = $fscanf(fd, "%s %d", name, len);
				mode_of[n_tests] = tok;
				name_of[n_tests] = name;
				len_of[n_tests]  = len;
				off_of[n_tests]  = next_off;
				errs_of[n_tests] = 0;
				for (int i = 0; i < len; i++) begin
					r = $fscanf(fd, "%h", b);
					frame_mem[next_off + i] = b;
				end
				// FCS bytes are listed in wire order with the least significant first
				for (int k = 0; k < 4; k++) begin
					r = $fscanf(fd, "%h", b);
					fcs_of[n_tests][8*k +: 8] = b;
				end
				good_of[n_tests] = 1'b1;
				if (tok == "R") begin
					r = $fscanf(fd, "%s", res);
					good_of[n_tests] = (res == "ok");
				end
				total_bytes += (tok == "L") ? 2 * (len + 4) : len + 4;
				next_off += len;
				n_tests++;
			end
		end
		$fclose(fd);
	endtask

	task automatic report_test(int t);
		if (errs_of[t] == 0) begin
			n_pass++;
			$display("%s %s ok", mode_of[t], name_of[t]);
		end else begin
			n_fail++;
			$display("%s %s failed with %0d errors", mode_of[t], name_of[t], errs_of[t]);
		end
	endtask

	// ------------------------------------------------------------------------
	// Transmit side
	// ------------------------------------------------------------------------

	// All T and L frames back to back with no idle beat between frames
	task automatic drive_tx();
		for (int t = 0; t < n_tests; t++) begin
			if (mode_of[t] != "R") begin
				for (int i = 0; i < len_of[t]; i++) begin
					tx_in_valid = 1'b1;
					tx_in_data  = frame_mem[off_of[t] + i];
					tx_in_last  = (i == len_of[t] - 1);
					@(negedge clk);
					while (!tx_in_ready) begin
						@(negedge clk);
					end
					@(posedge clk);
					#1;
				end
			end
		end
		tx_in_valid = 1'b0;
		tx_in_last  = 1'b0;
	endtask

	task automatic collect_tx();
		int    n;
		int    loop_next;
		logic  done;
		byte_t exp;
		loop_next = 0;
		for (int t = 0; t < n_tests; t++) begin
			if (mode_of[t] != "R") begin
				n    = 0;
				done = 1'b0;
				while (!done) begin
					@(negedge clk);
					if (tx_out_valid && tx_out_ready) begin
						if (n < len_of[t]) begin
							exp = frame_mem[off_of[t] + n];
						end else begin
							exp = fcs_of[t][8*(n - len_of[t]) +: 8];
						end
						assert (tx_out_data == exp) else begin
							$display("error %s byte %0d expected %02h actual %02h",
								name_of[t], n, exp, tx_out_data);
							errs_of[t]++;
						end
						assert (tx_out_last == (n == len_of[t] + 3)) else begin
							$display("error %s last on byte %0d expected %0b actual %0b",
								name_of[t], n, n == len_of[t] + 3, tx_out_last);
							errs_of[t]++;
						end
						loop_mem[loop_next + n] = tx_out_data;
						n++;
						done = tx_out_last || (n == len_of[t] + 4);
					end
				end
				loop_off[t] = loop_next;
				loop_len[t] = n;
				loop_next += n;
				if (mode_of[t] == "T") begin
					report_test(t);
				end
			end
		end
	endtask

	// No input byte may be taken until the fourth FCS byte has left
	always @(negedge clk) begin
		if (rst_n) begin
			if (fcs_pending) begin
				assert (!tx_in_ready) else begin
					$display("tx_in ready went high while FCS bytes were still pending");
					mon_errs++;
				end
			end
			if (tx_in_valid && tx_in_ready && tx_in_last) begin
				fcs_pending = 1'b1;
			end else if (tx_out_valid && tx_out_ready && tx_out_last) begin
				fcs_pending = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Receive side
	// ------------------------------------------------------------------------

	task automatic run_rx(int t);
		int    n;
		byte_t b;
		n = (mode_of[t] == "L") ? loop_len[t] : len_of[t] + 4;
		for (int i = 0; i < n; i++) begin
			if (mode_of[t] == "L") begin
				b = loop_mem[loop_off[t] + i];
			end else if (i < len_of[t]) begin
				b = frame_mem[off_of[t] + i];
			end else begin
				b = fcs_of[t][8*(i - len_of[t]) +: 8];
			end
			rx_valid = 1'b1;
			rx_data  = b;
			rx_last  = (i == n - 1);
			@(negedge clk);
			assert (!frame_ok && !frame_bad) else begin
				$display("%s gave a result pulse before its last byte", name_of[t]);
				errs_of[t]++;
			end
			@(posedge clk);
			#1;
		end
		rx_valid = 1'b0;
		rx_last  = 1'b0;
		// Result is due one cycle after the last byte
		@(negedge clk);
		assert (frame_ok == good_of[t] && frame_bad == !good_of[t]) else begin
			$display("error %s ok/bad expected %0b%0b actual %0b%0b", name_of[t],
				good_of[t], !good_of[t], frame_ok, frame_bad);
			errs_of[t]++;
		end
		@(posedge clk);
		#1;
		@(negedge clk);
		assert (!frame_ok && !frame_bad) else begin
			$display("%s result pulse lasted longer than one cycle", name_of[t]);
			errs_of[t]++;
		end
		@(posedge clk);
		#1;
	endtask

	// ------------------------------------------------------------------------
	// Sequence and watchdog
	// ------------------------------------------------------------------------

	initial begin
		rst_n       = 1'b0;
		tx_in_valid = 1'b0;
		tx_in_last  = 1'b0;
		tx_in_data  = '0;
		rx_valid    = 1'b0;
		rx_last     = 1'b0;
		rx_data     = '0;
		load_tests();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Idle outputs after reset
		@(negedge clk);
		assert (tx_in_ready && !tx_out_valid && !frame_ok && !frame_bad) else begin
			$display("outputs were not idle after reset");
			mon_errs++;
		end
		@(posedge clk);
		#1;
		fork
			drive_tx();
			collect_tx();
		join
		@(posedge clk);
		#1;
		for (int t = 0; t < n_tests; t++) begin
			if (mode_of[t] != "T") begin
				run_rx(t);
				report_test(t);
			end
		end
		$display("tests passed %0d, failed %0d, monitor errors %0d", n_pass, n_fail, mon_errs);
		if (n_fail == 0 && mon_errs == 0 && n_pass > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (RESET_CYCLES + total_bytes * 8 + 200) @(posedge clk);
		$display("timeout, the tests did not finish in the allowed number of cycles");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/eth_fcs_tests.txt */
# mode name count frame_bytes fcs0 fcs1 fcs2 fcs3 [ok|bad for R lines]
# mode T transmit, R receive, L loopback; FCS bytes least significant first
T check_digits 9 31 32 33 34 35 36 37 38 39 26 39 F4 CB
T single_a 1 61 43 BE B7 E8
T abc 3 61 62 63 C2 41 24 35
# Same frame twice with no gap between them
T repeat_first 9 31 32 33 34 35 36 37 38 39 26 39 F4 CB
T repeat_second 9 31 32 33 34 35 36 37 38 39 26 39 F4 CB
T zero_word 4 00 00 00 00 1C DF 44 21
T ones_word 4 FF FF FF FF FF FF FF FF
T single_zero 1 00 8D EF 02 D2
T digest 14 6D 65 73 73 61 67 65 20 64 69 67 65 73 74 7F 9D 15 20
T alphabet 26 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F 70 71 72 73 74 75 76 77 78 79 7A BD 50 27 4C
# Receive with correct and corrupted frames
R rx_digits 9 31 32 33 34 35 36 37 38 39 26 39 F4 CB ok
R rx_abc 3 61 62 63 C2 41 24 35 ok
R rx_zero 4 00 00 00 00 1C DF 44 21 ok
R rx_single_a 1 61 43 BE B7 E8 ok
R rx_bad_data 9 30 32 33 34 35 36 37 38 39 26 39 F4 CB bad
R rx_bad_fcs 9 31 32 33 34 35 36 37 38 39 26 39 F4 CA bad
R rx_bad_tail 3 61 62 62 C2 41 24 35 bad
R rx_bad_first 1 61 42 BE B7 E8 bad
# Transmit output replayed into the receiver
L loop_digits 9 31 32 33 34 35 36 37 38 39 26 39 F4 CB
L loop_digest 14 6D 65 73 73 61 67 65 20 64 69 67 65 73 74 7F 9D 15 20
L loop_abc 3 61 62 63 C2 41 24 35
L loop_alphabet 26 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F 70 71 72 73 74 75 76 77 78 79 7A BD 50 27 4C

/* verilog.f */
+incdir+include
logic/stream_pkg.sv
logic/eth_pkg.sv
logic/byte_stream_if.sv
logic/eth_crc.sv
logic/eth_fcs_append.sv
logic/eth_fcs_check.sv
logic/eth_fcs_top.sv
testbench/eth_fcs_tb.sv

/* Bender.yml */
package:
  name: eth_fcs

export_include_dirs:
  - include

sources:
  - files:
      - logic/stream_pkg.sv
      - logic/eth_pkg.sv
      - logic/byte_stream_if.sv
      - logic/eth_crc.sv
      - logic/eth_fcs_append.sv
      - logic/eth_fcs_check.sv
      - logic/eth_fcs_top.sv
  - target: test
    files:
      - testbench/eth_fcs_tb.sv
